//--- build.f
+incdir+include
design/smem_buf_pkg.sv
design/mem_write_router.sv
design/mem_bank.sv
design/output_sequencer.sv
design/smem_buf_top.sv
dv/smem_buf_tb.sv

//--- dv/smem_buf_tb.sv
`timescale 1ns/1ps
`include "smem_buf_config.svh"

module smem_buf_tb
	import smem_buf_pkg::*;
();
	typedef logic [`SMEM_READ_NUM_WIDTH:0] count_t;

	localparam int NREADS       = 64;
	localparam int SEED         = 11403;
	localparam int STREAM_STALL = 20;
	localparam int PERMIT_DROP  = 25;

	logic       clk;
	logic       reset_n;
	logic       stall;
	count_t     batch_size;
	logic       mem_we;
	read_num_t  mem_read_num;
	size_t      mem_addr;
	lane_word_t mem_data;
	logic       mem_size_valid;
	size_t      mem_size;
	read_num_t  mem_size_read_num;
	logic       ret_valid;
	size_t      ret;
	read_num_t  ret_read_num;
	logic       output_permit;
	count_t     done_counter;
	logic       output_request;
	out_beat_u  output_data;
	logic       output_valid;
	logic       output_finish;

	// one row per read, in read order
	// bits 29:24 read number, 23:16 mem count, 15:8 return code, 7:0 stall percent
	logic [31:0] read_table [NREADS] = '{
		32'h00_05_00_0a, 32'h01_14_7f_14, 32'h02_01_23_1e, 32'h03_08_41_28,
		32'h04_0b_05_00, 32'h05_02_3c_0a, 32'h06_13_12_14, 32'h07_06_66_1e,
		32'h08_03_01_28, 32'h09_0c_77_00, 32'h0a_11_2a_0a, 32'h0b_04_19_14,
		32'h0c_09_50_1e, 32'h0d_10_0e_28, 32'h0e_07_33_00, 32'h0f_0e_6b_0a,
		32'h10_01_04_14, 32'h11_12_5d_1e, 32'h12_05_21_28, 32'h13_0a_48_00,
		32'h14_0f_3f_0a, 32'h15_02_17_14, 32'h16_14_70_1e, 32'h17_0d_09_28,
		32'h18_06_2e_00, 32'h19_03_55_0a, 32'h1a_0b_13_14, 32'h1b_08_62_1e,
		32'h1c_13_07_28, 32'h1d_01_39_00, 32'h1e_0a_4c_0a, 32'h1f_04_1b_14,
		32'h20_07_02_1e, 32'h21_0e_6e_28, 32'h22_02_34_00, 32'h23_11_58_0a,
		32'h24_09_0b_14, 32'h25_0c_45_1e, 32'h26_05_27_28, 32'h27_14_7a_00,
		32'h28_03_16_0a, 32'h29_0d_60_14, 32'h2a_08_0d_1e, 32'h2b_01_3a_28,
		32'h2c_10_51_00, 32'h2d_06_1f_0a, 32'h2e_0f_68_14, 32'h2f_04_06_1e,
		32'h30_0b_43_28, 32'h31_02_2c_00, 32'h32_12_73_0a, 32'h33_07_10_14,
		32'h34_09_5a_1e, 32'h35_0e_25_28, 32'h36_03_4e_00, 32'h37_13_08_0a,
		32'h38_05_37_14, 32'h39_0a_64_1e, 32'h3a_01_1d_28, 32'h3b_0c_52_00,
		32'h3c_08_0a_0a, 32'h3d_11_47_14, 32'h3e_06_2f_1e, 32'h3f_14_7e_28
	};

	lane_word_t  stored [NREADS][`SMEM_READ_MAX_MEM];
	out_beat_u   exp_beats [$];
	bit          exp_hdr [$];
	logic [31:0] data_state;
	logic [31:0] rand_state;
	int          mode;
	int          cycles;
	int          cycle_limit;
	logic        prev_valid;
	logic        prev_frozen;
	logic        finish_seen;

	smem_buf_top dut (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ----------------------------------------
	task automatic stop_with_failure(string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_beat(string name, out_beat_u got, out_beat_u exp);
		if (got !== exp)
			stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(string name, count_t got, count_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic lane_word_t random_word();
		logic [255:0] flat;
		for (int k = 0; k < 8; k++) begin
			data_state = xorshift32(data_state);
			flat[k*32 +: 32] = data_state;
		end
		return flat;
	endfunction

	function automatic bit chance(int pct);
		rand_state = xorshift32(rand_state);
		return (rand_state % 100) < pct;
	endfunction

	// x0..x2 sit in the low 33 bits of lanes 0..2
	// lane 3 holds info_lo and info_hi
	function automatic lane_word_t keep_entry_bits(lane_word_t w);
		lane_word_t m;
		m = '0;
		m[0][32:0]  = w[0][32:0];
		m[1][32:0]  = w[1][32:0];
		m[2][32:0]  = w[2][32:0];
		m[3][6:0]   = w[3][6:0];
		m[3][38:32] = w[3][38:32];
		return m;
	endfunction

	// ----------------------------------------
	// inputs stay put until an edge without stall takes them
	task automatic hold_until_taken(int pct);
		logic frozen;
		frozen = 1'b1;
		while (frozen) begin
			frozen = (mode != 0) && chance(pct);
			stall  = frozen;
			@(posedge clk);
			#5;
		end
		stall = 1'b0;
	endtask

	task automatic apply_reset();
		reset_n        = 1'b0;
		stall          = 1'b0;
		mem_we         = 1'b0;
		mem_size_valid = 1'b0;
		ret_valid      = 1'b0;
		output_permit  = 1'b0;
		repeat (10) @(posedge clk);
		#5;
		reset_n = 1'b1;
		check_bit("output_request", output_request, 1'b0);
		check_bit("output_valid", output_valid, 1'b0);
		check_bit("output_finish", output_finish, 1'b0);
		check_count("done_counter", done_counter, '0);
	endtask

	task automatic write_entries();
		logic [31:0] row;
		lane_word_t  w;
		for (int r = 0; r < NREADS; r++) begin
			row = read_table[r];
			for (int i = 0; i < row[23:16]; i++) begin
				w = random_word();
				stored[row[29:24]][i] = keep_entry_bits(w);
				mem_we       = 1'b1;
				mem_read_num = row[29:24];
				mem_addr     = size_t'(i);
				mem_data     = w;
				hold_until_taken(int'(row[7:0]));
			end
		end
		mem_we = 1'b0;
	endtask

	task automatic send_reports();
		logic [31:0] row;
		for (int r = 0; r < NREADS; r++) begin
			row = read_table[r];
			mem_size_valid    = 1'b1;
			mem_size          = size_t'(row[23:16]);
			mem_size_read_num = row[29:24];
			ret_valid         = 1'b1;
			ret               = size_t'(row[15:8]);
			ret_read_num      = row[29:24];
			hold_until_taken(int'(row[7:0]));
			check_count("done_counter", done_counter, count_t'(r));
			check_bit("output_request", output_request, 1'b0);
		end
		mem_size_valid = 1'b0;
		ret_valid      = 1'b0;
	endtask

	task automatic build_expected();
		logic [31:0] row;
		out_beat_u   b;
		int          cnt;
		exp_beats.delete();
		exp_hdr.delete();
		for (int r = 0; r < NREADS; r++) begin
			row = read_table[r];
			cnt = row[23:16];
			b = '0;
			b.hdr.read_num = 64'(row[29:24]);
			b.hdr.mem_size = 64'(row[23:16]);
			b.hdr.ret_code = 32'(row[15:8]);
			exp_beats.push_back(b);
			exp_hdr.push_back(1'b1);
			for (int i = 0; i < cnt; i += 2) begin
				b = '0;
				b.pair.first = stored[row[29:24]][i];
				if (i + 1 < cnt)
					b.pair.second = stored[row[29:24]][i+1];
				exp_beats.push_back(b);
				exp_hdr.push_back(1'b0);
			end
		end
	endtask

	task automatic stream_batch();
		while (!output_request) begin
			@(posedge clk);
			#5;
		end
		check_count("done_counter", done_counter, count_t'(NREADS));
		while (!output_finish) begin
			stall         = (mode != 0) && chance(STREAM_STALL);
			output_permit = (mode != 2) || !chance(PERMIT_DROP);
			@(posedge clk);
			#5;
		end
		stall         = 1'b0;
		output_permit = 1'b1;
		if (exp_beats.size() != 0)
			stop_with_failure("output_finish is high but beats are still missing");
		repeat (8) @(posedge clk);
		#5;
		check_bit("output_finish", output_finish, 1'b1);
	endtask

	// ----------------------------------------
	// scoreboard sampled mid cycle
	always @(negedge clk) begin
		if (!reset_n) begin
			finish_seen = 1'b0;
		end else begin
			if (output_valid && prev_frozen)
				stop_with_failure("output_valid high in the cycle after a frozen edge");
			if (output_valid && exp_beats.size() == 0)
				stop_with_failure("a beat arrived with no beat left to expect");
			if (output_valid) begin
				if (exp_hdr[0] && prev_valid)
					stop_with_failure("header beat arrived with no idle cycle before it");
				check_beat("output_data", output_data, exp_beats.pop_front());
				void'(exp_hdr.pop_front());
			end
			if (output_finish && exp_beats.size() != 0)
				stop_with_failure("output_finish rose before the last beat");
			if (finish_seen && !output_finish)
				stop_with_failure("output_finish fell after rising");
			finish_seen = finish_seen | output_finish;
		end
		prev_valid  = output_valid;
		prev_frozen = stall | ~output_permit;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit)
			stop_with_failure($sformatf("Timeout: run still going after %0d cycles", cycles));
	end

	initial begin
		int writes;
		int beats;
		writes = 0;
		beats  = 0;
		for (int r = 0; r < NREADS; r++) begin
			writes += read_table[r][23:16];
			beats  += 1 + (read_table[r][23:16] + 1) / 2;
		end
		// three passes over the same batch
		cycle_limit = 4 * 3 * (writes + beats) + 500;
		cycles      = 0;
		prev_valid  = 1'b0;
		prev_frozen = 1'b0;
		finish_seen = 1'b0;
		rand_state  = SEED;
		data_state  = SEED;

		reset_n           = 1'b0;
		stall             = 1'b0;
		batch_size        = count_t'(NREADS);
		mem_we            = 1'b0;
		mem_read_num      = '0;
		mem_addr          = '0;
		mem_data          = '0;
		mem_size_valid    = 1'b0;
		mem_size          = '0;
		mem_size_read_num = '0;
		ret_valid         = 1'b0;
		ret               = '0;
		ret_read_num      = '0;
		output_permit     = 1'b0;

		// pass 0 clean, pass 1 random stall, pass 2 stall and permit drops
		for (mode = 0; mode < 3; mode++) begin
			apply_reset();
			output_permit = (mode != 2);
			write_entries();
			send_reports();
			build_expected();
			stream_batch();
			$display("pass %0d streamed %0d reads", mode, NREADS);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

//--- design/smem_buf_top.sv
`timescale 1ns/1ps
`include "smem_buf_config.svh"

module smem_buf_top
	import smem_buf_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          stall,
	input  logic [`SMEM_READ_NUM_WIDTH:0] batch_size,
	input  logic                          mem_we,
	input  read_num_t                     mem_read_num,
	input  size_t                         mem_addr,
	input  lane_word_t                    mem_data,
	input  logic                          mem_size_valid,
	input  size_t                         mem_size,
	input  read_num_t                     mem_size_read_num,
	input  logic                          ret_valid,
	input  size_t                         ret,
	input  read_num_t                     ret_read_num,
	input  logic                          output_permit,
	output logic [`SMEM_READ_NUM_WIDTH:0] done_counter,
	output logic                          output_request,
	output out_beat_u                     output_data,
	output logic                          output_valid,
	output logic                          output_finish
);

	logic                       link_hold;
	logic                       advance;
	read_num_t                  out_ptr;
	bank_addr_t                 out_addr_a;
	bank_addr_t                 out_addr_b;
	logic [`SMEM_NUM_BANKS-1:0] bank_we;
	bank_addr_t                 bank_addr_a;
	bank_addr_t                 bank_addr_b;
	entry_t                     bank_data;
	entry_t                     bank_q_a [`SMEM_NUM_BANKS];
	entry_t                     bank_q_b [`SMEM_NUM_BANKS];

	// once requested, port A and the bank reads pause with the walker
	assign link_hold = output_request & ~output_permit;
	assign advance   = ~(stall | link_hold);

	mem_write_router u_router (
		.clk          (clk),
		.reset_n      (reset_n),
		.stall        (~advance),
		.mem_we       (mem_we),
		.mem_read_num (mem_read_num),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.out_ptr      (out_ptr),
		.out_addr_a   (out_addr_a),
		.out_addr_b   (out_addr_b),
		.bank_we      (bank_we),
		.bank_addr_a  (bank_addr_a),
		.bank_addr_b  (bank_addr_b),
		.bank_data    (bank_data)
	);

	// ----------------------------------------
	for (genvar b = 0; b < `SMEM_NUM_BANKS; b++) begin : g_bank
		mem_bank u_bank (
			.clk     (clk),
			.read_en (advance),
			.we      (bank_we[b]),
			.addr_a  (bank_addr_a),
			.data    (bank_data),
			.q_a     (bank_q_a[b]),
			.addr_b  (bank_addr_b),
			.q_b     (bank_q_b[b])
		);
	end

	output_sequencer u_seq (
		.clk               (clk),
		.reset_n           (reset_n),
		.stall             (stall),
		.batch_size        (batch_size),
		.mem_size_valid    (mem_size_valid),
		.mem_size          (mem_size),
		.mem_size_read_num (mem_size_read_num),
		.ret_valid         (ret_valid),
		.ret               (ret),
		.ret_read_num      (ret_read_num),
		.output_permit     (output_permit),
		.bank_q_a          (bank_q_a),
		.bank_q_b          (bank_q_b),
		.out_ptr           (out_ptr),
		.out_addr_a        (out_addr_a),
		.out_addr_b        (out_addr_b),
		.done_counter      (done_counter),
		.output_request    (output_request),
		.output_data       (output_data),
		.output_valid      (output_valid),
		.output_finish     (output_finish)
	);

endmodule

//--- design/output_sequencer.sv
`timescale 1ns/1ps
`include "smem_buf_config.svh"

module output_sequencer
	import smem_buf_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          stall,
	input  logic [`SMEM_READ_NUM_WIDTH:0] batch_size,
	input  logic                          mem_size_valid,
	input  size_t                         mem_size,
	input  read_num_t                     mem_size_read_num,
	input  logic                          ret_valid,
	input  size_t                         ret,
	input  read_num_t                     ret_read_num,
	input  logic                          output_permit,
	input  entry_t                        bank_q_a [`SMEM_NUM_BANKS],
	input  entry_t                        bank_q_b [`SMEM_NUM_BANKS],
	output read_num_t                     out_ptr,
	output bank_addr_t                    out_addr_a,
	output bank_addr_t                    out_addr_b,
	output logic [`SMEM_READ_NUM_WIDTH:0] done_counter,
	output logic                          output_request,
	output out_beat_u                     output_data,
	output logic                          output_valid,
	output logic                          output_finish
);
	localparam int RNW = `SMEM_READ_NUM_WIDTH;
	localparam int DL  = 4;

	size_t size_tab [`SMEM_MAX_READ];
	size_t ret_tab [`SMEM_MAX_READ];

	logic      size_valid_q;
	size_t     size_q;
	read_num_t size_num_q;
	logic      ret_valid_q;
	size_t     ret_q;
	read_num_t ret_num_q;
	logic      all_done;

	logic         out_adv;
	logic [RNW:0] ptr;
	size_t        idx;
	size_t        cur_size;
	logic         group_start;
	logic         walk_end;
	logic         slot_vld;

	read_num_t dl_ptr [1:DL];
	size_t     dl_idx [1:DL];
	size_t     dl_size [1:DL];
	logic      dl_gs [1:DL];
	logic      dl_vld [1:DL];
	logic      dl_fin [1:DL];

	entry_t    q_a_r;
	entry_t    q_b_r;
	size_t     hdr_size;
	size_t     hdr_ret;
	out_beat_u beat;

	// ----------------------------------------
	// count and return reports
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			size_valid_q <= 1'b0;
			ret_valid_q  <= 1'b0;
		end else if (!stall) begin
			size_valid_q <= mem_size_valid;
			ret_valid_q  <= ret_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			size_q     <= mem_size;
			size_num_q <= mem_size_read_num;
			ret_q      <= ret;
			ret_num_q  <= ret_read_num;
			if (size_valid_q) begin
				size_tab[size_num_q] <= size_q;
			end
			if (ret_valid_q) begin
				ret_tab[ret_num_q] <= ret_q;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			done_counter   <= '0;
			all_done       <= 1'b0;
			output_request <= 1'b0;
		end else if (!stall) begin
			if (size_valid_q) begin
				done_counter <= done_counter + 1'b1;
			end
			all_done       <= (done_counter == batch_size) && (done_counter != '0);
			output_request <= all_done;
		end
	end

	// ----------------------------------------
	// group walker: header slot, entry pairs, then one gap slot
	assign out_adv    = ~stall & output_permit;
	assign walk_end   = (ptr >= batch_size);
	assign slot_vld   = output_request & ~walk_end & (group_start | (idx < cur_size));
	assign out_ptr    = ptr[RNW-1:0];
	assign out_addr_a = slot_addr(out_ptr, idx);
	assign out_addr_b = slot_addr(out_ptr, idx + 1'b1);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ptr         <= '0;
			idx         <= '0;
			cur_size    <= '0;
			group_start <= 1'b1;
		end else if (out_adv && output_request && !walk_end) begin
			if (group_start) begin
				group_start <= 1'b0;
				cur_size    <= size_tab[out_ptr];
				idx         <= '0;
			end else if (idx + 1'b1 < cur_size) begin
				idx <= idx + 2'd2;
			end else if (idx < cur_size) begin
				idx <= idx + 1'b1;
			end else begin
				ptr         <= ptr + 1'b1;
				group_start <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// delay line, stage 3 meets the bank read data
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int s = 1; s <= DL; s++) begin
				dl_vld[s] <= 1'b0;
				dl_fin[s] <= 1'b0;
			end
		end else if (out_adv) begin
			dl_vld[1] <= slot_vld;
			dl_fin[1] <= output_request & walk_end;
			for (int s = 2; s <= DL; s++) begin
				dl_vld[s] <= dl_vld[s-1];
				dl_fin[s] <= dl_fin[s-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_adv) begin
			dl_ptr[1]  <= out_ptr;
			dl_idx[1]  <= idx;
			dl_size[1] <= cur_size;
			dl_gs[1]   <= group_start;
			for (int s = 2; s <= DL; s++) begin
				dl_ptr[s]  <= dl_ptr[s-1];
				dl_idx[s]  <= dl_idx[s-1];
				dl_size[s] <= dl_size[s-1];
				dl_gs[s]   <= dl_gs[s-1];
			end
			// bank picked by the read number msbs
			q_a_r    <= bank_q_a[dl_ptr[3][RNW-1 -: `SMEM_BANK_BITS]];
			q_b_r    <= bank_q_b[dl_ptr[3][RNW-1 -: `SMEM_BANK_BITS]];
			hdr_size <= size_tab[dl_ptr[3]];
			hdr_ret  <= ret_tab[dl_ptr[3]];
		end
	end

	// ----------------------------------------
	// beat formatting
	always_comb begin
		beat = '0;
		if (dl_gs[DL]) begin
			beat.hdr.read_num = `SMEM_HDR_FIELD_BITS'(dl_ptr[DL]);
			beat.hdr.mem_size = `SMEM_HDR_FIELD_BITS'(hdr_size);
			beat.hdr.ret_code = `SMEM_HDR_RET_BITS'(hdr_ret);
		end else begin
			beat.pair.first = entry_to_lane(q_a_r);
			// odd tail keeps the high half zero
			if (dl_idx[DL] + 1'b1 < dl_size[DL]) begin
				beat.pair.second = entry_to_lane(q_b_r);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			output_valid  <= 1'b0;
			output_finish <= 1'b0;
		end else if (out_adv) begin
			output_valid  <= dl_vld[DL];
			output_finish <= dl_fin[DL];
		end else begin
			output_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (out_adv) begin
			output_data <= beat;
		end
	end

endmodule

//--- design/mem_bank.sv
`timescale 1ns/1ps
`include "smem_buf_config.svh"

module mem_bank
	import smem_buf_pkg::*;
(
	input  logic       clk,
	input  logic       read_en,
	input  logic       we,
	input  bank_addr_t addr_a,
	input  entry_t     data,
	output entry_t     q_a,
	input  bank_addr_t addr_b,
	output entry_t     q_b
);

	entry_t ram [`SMEM_BANK_DEPTH];

	// read_en doubles as the pipeline freeze
	always_ff @(posedge clk) begin
		if (read_en) begin
			if (we) begin
				ram[addr_a] <= data;
			end
			q_a <= ram[addr_a];
			q_b <= ram[addr_b];
		end
	end

endmodule

//--- design/mem_write_router.sv
`timescale 1ns/1ps
`include "smem_buf_config.svh"

module mem_write_router
	import smem_buf_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       stall,
	input  logic                       mem_we,
	input  read_num_t                  mem_read_num,
	input  size_t                      mem_addr,
	input  lane_word_t                 mem_data,
	input  read_num_t                  out_ptr,
	input  bank_addr_t                 out_addr_a,
	input  bank_addr_t                 out_addr_b,
	output logic [`SMEM_NUM_BANKS-1:0] bank_we,
	output bank_addr_t                 bank_addr_a,
	output bank_addr_t                 bank_addr_b,
	output entry_t                     bank_data
);
	localparam int RNW = `SMEM_READ_NUM_WIDTH;

	bank_addr_t wr_addr;
	logic       we_q;
	read_num_t  num_q;
	bank_addr_t addr_a_q;
	bank_addr_t addr_b_q;
	entry_t     data_q;

	assign wr_addr = slot_addr(mem_read_num, mem_addr);

	// ----------------------------------------
	// write strobe, decoded to one bank on the second stage
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			we_q    <= 1'b0;
			bank_we <= '0;
		end else if (!stall) begin
			we_q    <= mem_we;
			bank_we <= '0;
			if (we_q) begin
				bank_we[num_q[RNW-1 -: `SMEM_BANK_BITS]] <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// port A owner: a datapath write beats the output read
	always_ff @(posedge clk) begin
		if (!stall) begin
			if (mem_we) begin
				num_q    <= mem_read_num;
				addr_a_q <= wr_addr;
			end else begin
				num_q    <= out_ptr;
				addr_a_q <= out_addr_a;
			end
			addr_b_q <= out_addr_b;
			data_q   <= lane_to_entry(mem_data);

			bank_addr_a <= addr_a_q;
			bank_addr_b <= addr_b_q;
			bank_data   <= data_q;
		end
	end

endmodule

//--- design/smem_buf_pkg.sv
`include "smem_buf_config.svh"

package smem_buf_pkg;

	typedef logic [`SMEM_READ_NUM_WIDTH-1:0]  read_num_t;
	typedef logic [`SMEM_SIZE_WIDTH-1:0]      size_t;
	typedef logic [`SMEM_BANK_ADDR_WIDTH-1:0] bank_addr_t;

	// stored entry, 113 bits
	typedef struct packed {
		logic [`SMEM_INFO_WIDTH-1:0] info_hi;
		logic [`SMEM_INFO_WIDTH-1:0] info_lo;
		logic [`SMEM_X_WIDTH-1:0]    x2;
		logic [`SMEM_X_WIDTH-1:0]    x1;
		logic [`SMEM_X_WIDTH-1:0]    x0;
	} entry_t;

	typedef logic [`SMEM_LANES-1:0][`SMEM_LANE_BITS-1:0] lane_word_t;

	typedef struct packed {
		logic [`SMEM_HDR_PAD_BITS-1:0]   pad;
		logic [`SMEM_HDR_RET_BITS-1:0]   ret_code;
		logic [`SMEM_HDR_FIELD_BITS-1:0] mem_size;
		logic [`SMEM_HDR_FIELD_BITS-1:0] read_num;
	} beat_header_t;

	typedef struct packed {
		lane_word_t second;
		lane_word_t first;
	} beat_pair_t;

	// one output beat, either a read header or two entries
	typedef union packed {
		beat_header_t hdr;
		beat_pair_t   pair;
	} out_beat_u;

	// ----------------------------------------
	function automatic entry_t lane_to_entry(lane_word_t w);
		entry_t e;
		e.x0      = w[0][`SMEM_X_WIDTH-1:0];
		e.x1      = w[1][`SMEM_X_WIDTH-1:0];
		e.x2      = w[2][`SMEM_X_WIDTH-1:0];
		e.info_lo = w[3][`SMEM_INFO_WIDTH-1:0];
		e.info_hi = w[3][`SMEM_INFO_HI_POS +: `SMEM_INFO_WIDTH];
		return e;
	endfunction

	function automatic lane_word_t entry_to_lane(entry_t e);
		lane_word_t w;
		w = '0;
		w[0][`SMEM_X_WIDTH-1:0]                      = e.x0;
		w[1][`SMEM_X_WIDTH-1:0]                      = e.x1;
		w[2][`SMEM_X_WIDTH-1:0]                      = e.x2;
		w[3][`SMEM_INFO_WIDTH-1:0]                   = e.info_lo;
		w[3][`SMEM_INFO_HI_POS +: `SMEM_INFO_WIDTH]  = e.info_hi;
		return w;
	endfunction

	// slot of entry i of read n inside its bank
	function automatic bank_addr_t slot_addr(read_num_t n, size_t i);
		bank_addr_t base;
		base = bank_addr_t'(n[`SMEM_READ_NUM_WIDTH-`SMEM_BANK_BITS-1:0]);
		return base * bank_addr_t'(`SMEM_READ_MAX_MEM) + bank_addr_t'(i);
	endfunction

endpackage

//--- include/smem_buf_config.svh
`ifndef SMEM_BUF_CONFIG_SVH
`define SMEM_BUF_CONFIG_SVH

// batch and bank sizing
`define SMEM_MAX_READ        64
`define SMEM_READ_NUM_WIDTH  6
`define SMEM_BANK_BITS       3
`define SMEM_NUM_BANKS       8
`define SMEM_READ_MAX_MEM    20
`define SMEM_SIZE_WIDTH      7
`define SMEM_BANK_DEPTH      (`SMEM_MAX_READ / `SMEM_NUM_BANKS * `SMEM_READ_MAX_MEM)
`define SMEM_BANK_ADDR_WIDTH 8

// word layouts
`define SMEM_LANE_WIDTH      256
`define SMEM_LANES           4
`define SMEM_LANE_BITS       (`SMEM_LANE_WIDTH / `SMEM_LANES)
`define SMEM_BEAT_WIDTH      512
`define SMEM_X_WIDTH         33
`define SMEM_INFO_WIDTH      7
`define SMEM_INFO_HI_POS     32
`define SMEM_HDR_FIELD_BITS  64
`define SMEM_HDR_RET_BITS    32
`define SMEM_HDR_PAD_BITS    (`SMEM_BEAT_WIDTH - 2 * `SMEM_HDR_FIELD_BITS - `SMEM_HDR_RET_BITS)

`endif
